// ==== common/mem_port_if.sv ====
interface mem_port_if;

	// request side, a level offered each cycle
	logic [slurm16_mem_pkg::ADDR_BITS-1:0] address;
	logic                                  rd_req;
	logic                                  wr_req;
	logic [slurm16_mem_pkg::DATA_BITS-1:0] wr_data;

	// return side
	logic                                  grant;	// request forwarded this cycle
	logic                                  success;	// one cycle pulse per finished access
	logic [slurm16_mem_pkg::ADDR_BITS-1:0] requested_address;
	logic [slurm16_mem_pkg::DATA_BITS-1:0] rd_data;

	modport requester (
		output address, rd_req, wr_req, wr_data,
		input  grant, success, requested_address, rd_data
	);

	modport arbiter (
		input  address, rd_req, wr_req, wr_data,
		output grant, success, requested_address, rd_data
	);

endinterface

// ==== common/slurm16_mem_pkg.sv ====
package slurm16_mem_pkg;

	// word address and data widths of the processor
	localparam int ADDR_BITS = 15;
	localparam int DATA_BITS = 16;

	// 256 direct mapped lines
	localparam int CACHE_DEPTH_BITS = 8;

	// prefetch block is 16 words, aligned
	localparam int FILL_BITS = 4;

	// cycles from a granted read to its data on the return path
	localparam int MEM_LATENCY = 2;

	// one cache line holds the full word address as its tag
	typedef struct packed {
		logic [ADDR_BITS-1:0] tag;
		logic [DATA_BITS-1:0] word;
	} icache_line_t;

	// which requester an access in flight belongs to
	typedef enum logic {
		OWNER_ICACHE = 1'b0,
		OWNER_DATA   = 1'b1
	} mem_owner_e;

endpackage

// ==== hdl/slurm16_data_port.sv ====
module slurm16_data_port (
	input  logic                                  CLK,
	input  logic                                  RSTb,

	// processor side, four phase handshake
	input  logic                                  data_req,
	input  logic                                  data_we,
	input  logic [slurm16_mem_pkg::ADDR_BITS-1:0] data_address,
	input  logic [slurm16_mem_pkg::DATA_BITS-1:0] data_wr_data,
	output logic                                  data_ack,
	output logic [slurm16_mem_pkg::DATA_BITS-1:0] data_rd_data,

	mem_port_if.requester                         bus
);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_ISSUE,
		ST_WAIT,
		ST_ACK
	} port_state_e;

	port_state_e state;
	logic        issuing;

	// offer straight from data_req in idle so the access starts at once
	assign issuing = (state == ST_ISSUE) || ((state == ST_IDLE) && data_req);

	// processor holds its fields stable while data_req is high
	assign bus.address = data_address;
	assign bus.wr_data = data_wr_data;
	assign bus.rd_req  = issuing && !data_we;
	assign bus.wr_req  = issuing && data_we;

	assign data_ack = (state == ST_ACK);

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			state <= ST_IDLE;
		end else begin
			case (state)
				ST_IDLE: begin
					if (data_req) begin
						state <= bus.grant ? ST_WAIT : ST_ISSUE;
					end
				end
				ST_ISSUE: begin
					if (bus.grant) begin	// keep offering until taken
						state <= ST_WAIT;
					end
				end
				ST_WAIT: begin
					if (bus.success) begin
						state <= ST_ACK;
					end
				end
				ST_ACK: begin
					if (!data_req) begin	// processor has seen ack
						state <= ST_IDLE;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// returned word, held through the ack phase
	always_ff @(posedge CLK) begin
		if ((state == ST_WAIT) && bus.success) begin
			data_rd_data <= bus.rd_data;
		end
	end

endmodule

// ==== hdl/slurm16_mem_arbiter.sv ====
module slurm16_mem_arbiter (
	input  logic                                  CLK,
	input  logic                                  RSTb,

	mem_port_if.arbiter                           icache_bus,
	mem_port_if.arbiter                           data_bus,

	// external memory bus, read data MEM_LATENCY cycles after the request cycle
	output logic [slurm16_mem_pkg::ADDR_BITS-1:0] mem_address,
	output logic                                  mem_rd,
	output logic                                  mem_wr,
	output logic [slurm16_mem_pkg::DATA_BITS-1:0] mem_wr_data,
	input  logic [slurm16_mem_pkg::DATA_BITS-1:0] mem_rd_data
);

	logic data_sel;

	// one entry per access in flight
	logic [slurm16_mem_pkg::MEM_LATENCY-1:0] pipe_valid;
	logic [slurm16_mem_pkg::MEM_LATENCY-1:0] pipe_rd;
	slurm16_mem_pkg::mem_owner_e             pipe_owner [slurm16_mem_pkg::MEM_LATENCY];
	logic [slurm16_mem_pkg::ADDR_BITS-1:0]   pipe_addr [slurm16_mem_pkg::MEM_LATENCY];

	logic rd_done;
	logic wr_done;
	logic rd_icache;
	logic wr_icache;
	logic rd_data_port;
	logic wr_data_port;

	// data port has fixed priority
	assign data_sel         = data_bus.rd_req || data_bus.wr_req;
	assign data_bus.grant   = data_sel;
	assign icache_bus.grant = (icache_bus.rd_req || icache_bus.wr_req) && !data_sel;

	// winner goes out in its grant cycle, the loser is dropped
	assign mem_address = data_sel ? data_bus.address : icache_bus.address;
	assign mem_wr_data = data_sel ? data_bus.wr_data : icache_bus.wr_data;
	assign mem_rd      = data_sel ? data_bus.rd_req  : icache_bus.rd_req;
	assign mem_wr      = data_sel ? data_bus.wr_req  : icache_bus.wr_req;

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			pipe_valid <= '0;
		end else begin
			pipe_valid <= {pipe_valid[slurm16_mem_pkg::MEM_LATENCY-2:0], mem_rd || mem_wr};
		end
	end

	always_ff @(posedge CLK) begin
		pipe_rd[0]    <= mem_rd;
		pipe_owner[0] <= data_sel ? slurm16_mem_pkg::OWNER_DATA : slurm16_mem_pkg::OWNER_ICACHE;
		pipe_addr[0]  <= mem_address;
		for (int i = 1; i < slurm16_mem_pkg::MEM_LATENCY; i++) begin
			pipe_rd[i]    <= pipe_rd[i-1];
			pipe_owner[i] <= pipe_owner[i-1];
			pipe_addr[i]  <= pipe_addr[i-1];
		end
	end

	// reads finish at the last stage, writes after the first
	assign rd_done = pipe_valid[slurm16_mem_pkg::MEM_LATENCY-1] &&
		pipe_rd[slurm16_mem_pkg::MEM_LATENCY-1];
	assign wr_done = pipe_valid[0] && !pipe_rd[0];

	assign rd_icache    = rd_done &&
		(pipe_owner[slurm16_mem_pkg::MEM_LATENCY-1] == slurm16_mem_pkg::OWNER_ICACHE);
	assign rd_data_port = rd_done &&
		(pipe_owner[slurm16_mem_pkg::MEM_LATENCY-1] == slurm16_mem_pkg::OWNER_DATA);
	assign wr_icache    = wr_done && (pipe_owner[0] == slurm16_mem_pkg::OWNER_ICACHE);
	assign wr_data_port = wr_done && (pipe_owner[0] == slurm16_mem_pkg::OWNER_DATA);

	assign icache_bus.success           = rd_icache || wr_icache;
	assign icache_bus.requested_address = rd_icache ?
		pipe_addr[slurm16_mem_pkg::MEM_LATENCY-1] : pipe_addr[0];
	assign icache_bus.rd_data           = mem_rd_data;

	assign data_bus.success           = rd_data_port || wr_data_port;
	assign data_bus.requested_address = rd_data_port ?
		pipe_addr[slurm16_mem_pkg::MEM_LATENCY-1] : pipe_addr[0];
	assign data_bus.rd_data           = mem_rd_data;

endmodule

// ==== hdl/slurm16_mem_subsystem.sv ====
module slurm16_mem_subsystem (
	input  logic                                  CLK,
	input  logic                                  RSTb,

	// instruction fetch
	input  logic [slurm16_mem_pkg::ADDR_BITS-1:0] fetch_address,
	output logic [slurm16_mem_pkg::DATA_BITS-1:0] fetch_data,
	output logic                                  fetch_miss,

	// loads and stores
	input  logic                                  data_req,
	input  logic                                  data_we,
	input  logic [slurm16_mem_pkg::ADDR_BITS-1:0] data_address,
	input  logic [slurm16_mem_pkg::DATA_BITS-1:0] data_wr_data,
	output logic                                  data_ack,
	output logic [slurm16_mem_pkg::DATA_BITS-1:0] data_rd_data,

	// external memory
	output logic [slurm16_mem_pkg::ADDR_BITS-1:0] mem_address,
	output logic                                  mem_rd,
	output logic                                  mem_wr,
	output logic [slurm16_mem_pkg::DATA_BITS-1:0] mem_wr_data,
	input  logic [slurm16_mem_pkg::DATA_BITS-1:0] mem_rd_data
);

	mem_port_if icache_bus ();
	mem_port_if data_bus ();

	slurm16_instruction_cache u_icache (
		.CLK           (CLK),
		.RSTb          (RSTb),
		.fetch_address (fetch_address),
		.fetch_data    (fetch_data),
		.fetch_miss    (fetch_miss),
		.bus           (icache_bus.requester)
	);

	slurm16_data_port u_data_port (
		.CLK          (CLK),
		.RSTb         (RSTb),
		.data_req     (data_req),
		.data_we      (data_we),
		.data_address (data_address),
		.data_wr_data (data_wr_data),
		.data_ack     (data_ack),
		.data_rd_data (data_rd_data),
		.bus          (data_bus.requester)
	);

	// single external bus shared by both requesters
	slurm16_mem_arbiter u_arbiter (
		.CLK         (CLK),
		.RSTb        (RSTb),
		.icache_bus  (icache_bus.arbiter),
		.data_bus    (data_bus.arbiter),
		.mem_address (mem_address),
		.mem_rd      (mem_rd),
		.mem_wr      (mem_wr),
		.mem_wr_data (mem_wr_data),
		.mem_rd_data (mem_rd_data)
	);

endmodule

// ==== icache/slurm16_instruction_cache.sv ====
module slurm16_instruction_cache (
	input  logic                                  CLK,
	input  logic                                  RSTb,

	input  logic [slurm16_mem_pkg::ADDR_BITS-1:0] fetch_address,
	output logic [slurm16_mem_pkg::DATA_BITS-1:0] fetch_data,
	output logic                                  fetch_miss,

	mem_port_if.requester                         bus
);

	// cache storage
	slurm16_mem_pkg::icache_line_t ram [(1 << slurm16_mem_pkg::CACHE_DEPTH_BITS)];
	logic [(1 << slurm16_mem_pkg::CACHE_DEPTH_BITS)-1:0] line_valid;

	// lookup stage
	logic [slurm16_mem_pkg::CACHE_DEPTH_BITS-1:0] fetch_idx;
	slurm16_mem_pkg::icache_line_t                line_q;
	logic                                         valid_q;
	logic [slurm16_mem_pkg::ADDR_BITS-1:0]        look_addr;
	logic [slurm16_mem_pkg::ADDR_BITS-1:0]        prev_addr;

	// fill side
	logic [slurm16_mem_pkg::CACHE_DEPTH_BITS-1:0]                  wr_idx;
	slurm16_mem_pkg::icache_line_t                                 fill_line;
	logic [slurm16_mem_pkg::FILL_BITS:0]                           fill_cnt;
	logic [slurm16_mem_pkg::ADDR_BITS-1:slurm16_mem_pkg::FILL_BITS] fill_base;
	logic [slurm16_mem_pkg::FILL_BITS-1:0]                         fill_off;
	logic                                                          fill_idle;
	logic                                                          fill_start;

	assign fetch_idx = fetch_address[slurm16_mem_pkg::CACHE_DEPTH_BITS-1:0];
	assign wr_idx    = bus.requested_address[slurm16_mem_pkg::CACHE_DEPTH_BITS-1:0];

	// returned word goes where its own address says
	assign fill_line.tag  = bus.requested_address;
	assign fill_line.word = bus.rd_data;

	assign fetch_data = line_q.word;
	assign fetch_miss = !valid_q || (line_q.tag != look_addr);	// tag compare on full address

	// top bit of the counter set means the block walk is done
	assign fill_idle = fill_cnt[slurm16_mem_pkg::FILL_BITS];

	// restart on a fresh miss, or on a miss still there once the walk is over
	assign fill_start = fetch_miss && ((look_addr != prev_addr) || fill_idle);

	// missed word first, then wrap around the aligned block
	assign bus.address = {fill_base, fill_off + fill_cnt[slurm16_mem_pkg::FILL_BITS-1:0]};
	assign bus.rd_req  = !fill_idle;
	assign bus.wr_req  = 1'b0;	// read only
	assign bus.wr_data = '0;

	always_ff @(posedge CLK) begin
		if (bus.success) begin
			ram[wr_idx] <= fill_line;
		end
		line_q <= ram[fetch_idx];	// registered read, one cycle lookup
	end

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			line_valid <= '0;
			valid_q    <= 1'b0;
			look_addr  <= '0;
			prev_addr  <= '0;
			fill_cnt   <= {1'b1, {slurm16_mem_pkg::FILL_BITS{1'b0}}};
		end else begin
			if (bus.success) begin
				line_valid[wr_idx] <= 1'b1;
			end
			valid_q   <= line_valid[fetch_idx];
			look_addr <= fetch_address;
			prev_addr <= look_addr;

			if (fill_start) begin
				fill_cnt <= '0;
			end else if (!fill_idle) begin
				fill_cnt <= fill_cnt + 1'b1;	// slot is used up even when not granted
			end
		end
	end

	// block and start word of the current walk
	always_ff @(posedge CLK) begin
		if (fill_start) begin
			fill_base <= look_addr[slurm16_mem_pkg::ADDR_BITS-1:slurm16_mem_pkg::FILL_BITS];
			fill_off  <= look_addr[slurm16_mem_pkg::FILL_BITS-1:0];
		end
	end

endmodule

// ==== src.f ====
common/slurm16_mem_pkg.sv
common/mem_port_if.sv
icache/slurm16_instruction_cache.sv
hdl/slurm16_data_port.sv
hdl/slurm16_mem_arbiter.sv
hdl/slurm16_mem_subsystem.sv
verif/tb_mem_model.sv
verif/tb_slurm16_mem.sv

// ==== verif/tb_mem_model.sv ====
module tb_mem_model (
	input  logic                                  CLK,
	input  logic [slurm16_mem_pkg::ADDR_BITS-1:0] mem_address,
	input  logic                                  mem_rd,
	input  logic                                  mem_wr,
	input  logic [slurm16_mem_pkg::DATA_BITS-1:0] mem_wr_data,
	output logic [slurm16_mem_pkg::DATA_BITS-1:0] mem_rd_data
);
	timeunit 1ns;
	timeprecision 100ps;

	localparam int WORDS = 1 << slurm16_mem_pkg::ADDR_BITS;

	logic [slurm16_mem_pkg::DATA_BITS-1:0] mem [WORDS];
	logic [slurm16_mem_pkg::ADDR_BITS-1:0] rd_addr_q;	// read address, first stage

	// one process owns the array, from preload through every access
	initial begin
		for (int a = 0; a < WORDS; a++) begin
			mem[a] = 16'(a) ^ 16'h5a3c;	// content before any write
		end
		rd_addr_q   = '0;
		mem_rd_data = '0;
		forever begin
			@(posedge CLK);
			if (mem_wr) begin
				mem[mem_address] <= mem_wr_data;
			end
			if (mem_rd) begin
				rd_addr_q <= mem_address;
			end
			// second stage, data is on the bus two cycles after the read cycle
			mem_rd_data <= mem[rd_addr_q];
		end
	end

endmodule

// ==== verif/tb_slurm16_mem.sv ====
module tb_slurm16_mem;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int FETCH_RANDOM = 40;
	localparam int BLOCK_WORDS  = 1 << slurm16_mem_pkg::FILL_BITS;
	localparam int DATA_READS   = 30;
	localparam int DATA_WRITES  = 20;
	localparam int MIXED_OPS    = 30;
	localparam int NUM_OPS      = 1 + FETCH_RANDOM + BLOCK_WORDS + DATA_READS +
		2 * DATA_WRITES + 2 * MIXED_OPS;
	localparam int CYCLE_LIMIT  = 40 * NUM_OPS;

	logic                                  CLK;
	logic                                  RSTb;
	logic [slurm16_mem_pkg::ADDR_BITS-1:0] fetch_address;
	logic [slurm16_mem_pkg::DATA_BITS-1:0] fetch_data;
	logic                                  fetch_miss;
	logic                                  data_req;
	logic                                  data_we;
	logic [slurm16_mem_pkg::ADDR_BITS-1:0] data_address;
	logic [slurm16_mem_pkg::DATA_BITS-1:0] data_wr_data;
	logic                                  data_ack;
	logic [slurm16_mem_pkg::DATA_BITS-1:0] data_rd_data;
	logic [slurm16_mem_pkg::ADDR_BITS-1:0] mem_address;
	logic                                  mem_rd;
	logic                                  mem_wr;
	logic [slurm16_mem_pkg::DATA_BITS-1:0] mem_wr_data;
	logic [slurm16_mem_pkg::DATA_BITS-1:0] mem_rd_data;

	logic [slurm16_mem_pkg::DATA_BITS-1:0] ref_mem [1 << slurm16_mem_pkg::ADDR_BITS];
	int   error_count = 0;
	int   check_count = 0;
	int   cycle_count = 0;
	logic ack_prev = 1'b0;
	logic req_prev = 1'b0;

	slurm16_mem_subsystem uut (.*);
	tb_mem_model u_mem (.*);

	initial begin
		CLK = 1'b0;
		forever #4 CLK = ~CLK;
	end

	function automatic logic [15:0] content_rule(input logic [14:0] addr);
		return {1'b0, addr} ^ 16'h5a3c;
	endfunction

	function automatic logic [14:0] fetch_rand_addr();
		return 15'($urandom & 32'h3fff);	// low half is the fetch region
	endfunction

	function automatic logic [14:0] data_rand_addr();
		return 15'h4000 | 15'($urandom & 32'h3fff);
	endfunction

	task automatic check_value(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		check_count++;
		if (actual !== expected) begin
			error_count++;
			$display("Error at %0t: %s is %h, expected %h", $time, name, actual, expected);
		end
	endtask

	task automatic report_test(input string name, input int errors_before);
		$display("Test %s done, %0d errors", name, error_count - errors_before);
	endtask

	// hold the address until the cache stops missing
	task automatic fetch_word(input logic [14:0] addr);
		fetch_address = addr;
		do begin
			@(posedge CLK);
			#1;
		end while (fetch_miss);
		check_value("fetch_data", fetch_data, content_rule(addr));
	endtask

	// one full four phase access
	task automatic data_access(input logic we, input logic [14:0] addr,
		input logic [15:0] wdata, output logic [15:0] rdata);
		data_we      = we;
		data_address = addr;
		data_wr_data = wdata;
		data_req     = 1'b1;
		do begin
			@(posedge CLK);
			#1;
		end while (!data_ack);
		rdata    = data_rd_data;
		data_req = 1'b0;
		do begin
			@(posedge CLK);
			#1;
		end while (data_ack);
	endtask

	// ack edges checked against data_req as it stood at the edge that moved ack
	always @(negedge CLK) begin
		if (RSTb) begin
			if (data_ack && !ack_prev) begin
				check_value("data_req at data_ack rise", req_prev, 1);
			end
			if (!data_ack && ack_prev) begin
				check_value("data_req at data_ack fall", req_prev, 0);
			end
		end
		ack_prev = data_ack;
		req_prev = data_req;
	end

	initial begin : watchdog
		while (cycle_count < CYCLE_LIMIT) begin
			@(posedge CLK);
			cycle_count++;
		end
		$display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
		$display("Finished with errors");
		$finish;
	end

	initial begin
		logic [14:0] addr;
		logic [15:0] word;
		logic [14:0] block_base;
		logic [14:0] wr_addrs [$];
		int          mark;

		void'($urandom(32'hb185_ce6c));
		RSTb          = 1'b0;
		fetch_address = '0;
		data_req      = 1'b0;
		data_we       = 1'b0;
		data_address  = '0;
		data_wr_data  = '0;
		for (int a = 0; a < (1 << slurm16_mem_pkg::ADDR_BITS); a++) begin
			ref_mem[a] = content_rule(15'(a));
		end

		// 1: reset state and the first fetch
		mark = error_count;
		addr = fetch_rand_addr();
		fetch_address = addr;
		repeat (5) @(posedge CLK);
		#1;
		RSTb = 1'b1;
		check_value("fetch_miss", fetch_miss, 1);	// valid bits all clear
		check_value("mem_rd", mem_rd, 0);
		check_value("mem_wr", mem_wr, 0);
		check_value("data_ack", data_ack, 0);
		fetch_word(addr);
		report_test("1 reset and first fetch", mark);

		// 2: random fetches
		mark = error_count;
		for (int i = 0; i < FETCH_RANDOM; i++) begin
			fetch_word(fetch_rand_addr());
		end
		report_test("2 random fetches", mark);

		// 3: walk one aligned block, words after the first come from the prefetch
		mark = error_count;
		block_base = fetch_rand_addr() & 15'h3ff0;
		for (int i = 0; i < BLOCK_WORDS; i++) begin
			fetch_word(block_base | 15'(i));
		end
		report_test("3 sequential block", mark);

		// 4: random reads
		mark = error_count;
		for (int i = 0; i < DATA_READS; i++) begin
			addr = data_rand_addr();
			data_access(1'b0, addr, '0, word);
			check_value("data_rd_data", word, ref_mem[addr]);
		end
		report_test("4 random reads", mark);

		// 5: writes then read back
		mark = error_count;
		for (int i = 0; i < DATA_WRITES; i++) begin
			addr = data_rand_addr();
			data_access(1'b1, addr, 16'($urandom), word);
			ref_mem[addr] = data_wr_data;
			wr_addrs.push_back(addr);
		end
		foreach (wr_addrs[i]) begin
			data_access(1'b0, wr_addrs[i], '0, word);
			check_value("data_rd_data", word, ref_mem[wr_addrs[i]]);
		end
		report_test("5 write and read back", mark);

		// 6: fetches and data traffic at the same time
		mark = error_count;
		fork
			begin : fetch_side
				for (int i = 0; i < MIXED_OPS; i++) begin
					fetch_word(fetch_rand_addr());
				end
			end
			begin : data_side
				logic [14:0] d_addr;
				logic [15:0] d_word;
				for (int i = 0; i < MIXED_OPS; i++) begin
					d_addr = data_rand_addr();
					if ($urandom & 1) begin
						d_word = 16'($urandom);
						ref_mem[d_addr] = d_word;
						data_access(1'b1, d_addr, d_word, d_word);
					end else begin
						data_access(1'b0, d_addr, '0, d_word);
						check_value("data_rd_data", d_word, ref_mem[d_addr]);
					end
				end
			end
		join
		report_test("6 concurrent traffic", mark);

		$display("Checks: %0d, errors: %0d, cycles: %0d", check_count, error_count,
			cycle_count);
		if (error_count == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule
